// File: design/alu_ops_pkg.sv
// alu data word and opcodes
`default_nettype none

package alu_ops_pkg;

  localparam int word_bits = 64;
  localparam int half_bits = 32;

  typedef logic [word_bits-1:0] word_t;
  typedef logic [4:0] op_t;

  // arithmetic
  localparam op_t op_add64 = 5'd0;
  localparam op_t op_add32 = 5'd1;
  localparam op_t op_sub64 = 5'd2;
  localparam op_t op_sub32 = 5'd3;

  // bitwise
  localparam op_t op_and64 = 5'd4;
  localparam op_t op_and32 = 5'd5;
  localparam op_t op_or64 = 5'd6;
  localparam op_t op_or32 = 5'd7;
  localparam op_t op_xor64 = 5'd8;
  localparam op_t op_xor32 = 5'd9;
  localparam op_t op_xnor64 = 5'd10;
  localparam op_t op_xnor32 = 5'd11;

  localparam op_t op_mov64 = 5'd12;
  localparam op_t op_mov32 = 5'd13;
  localparam op_t op_zxt8 = 5'd14;
  localparam op_t op_zxt16 = 5'd15;
  localparam op_t op_sxt8 = 5'd16;
  localparam op_t op_sxt16 = 5'd17;
  localparam op_t op_sxt32 = 5'd18;
  localparam op_t op_cmov = 5'd19;   // b if cond holds, else a
  localparam op_t op_cset = 5'd20;
  // 21..31 unused

endpackage

`default_nettype wire

// File: design/alu_flags_pkg.sv
// alu flag word and condition codes
`default_nettype none

package alu_flags_pkg;

  typedef logic [5:0] flags_t;  // C O A S Z P
  typedef logic [3:0] cond_t;

  localparam int flag_c = 5;
  localparam int flag_o = 4;
  localparam int flag_a = 3;
  localparam int flag_s = 2;
  localparam int flag_z = 1;
  localparam int flag_p = 0;

  localparam cond_t cond_z = 4'd0;
  localparam cond_t cond_nz = 4'd1;
  localparam cond_t cond_s = 4'd2;
  localparam cond_t cond_ns = 4'd3;
  // unsigned, C read as borrow
  localparam cond_t cond_ugt = 4'd4;
  localparam cond_t cond_ule = 4'd5;
  localparam cond_t cond_uge = 4'd6;
  localparam cond_t cond_ult = 4'd7;
  localparam cond_t cond_sgt = 4'd8;
  localparam cond_t cond_sle = 4'd9;
  localparam cond_t cond_sge = 4'd10;
  localparam cond_t cond_slt = 4'd11;
  localparam cond_t cond_o = 4'd12;
  localparam cond_t cond_no = 4'd13;
  localparam cond_t cond_p = 4'd14;
  localparam cond_t cond_always = 4'd15;

endpackage

`default_nettype wire

// File: design/cond_eval.sv
// condition code evaluation
`timescale 1ns/1ps
`default_nettype none

module cond_eval (
  input  wire alu_flags_pkg::flags_t flags,
  input  wire alu_flags_pkg::cond_t  cond,
  output logic                       taken
);
  import alu_flags_pkg::*;

  logic c, o, s, z, p;
  logic lt;  // signed less than

  assign c = flags[flag_c];
  assign o = flags[flag_o];
  assign s = flags[flag_s];
  assign z = flags[flag_z];
  assign p = flags[flag_p];
  assign lt = s ^ o;

  always_comb begin
    case (cond)
      cond_z:      taken = z;
      cond_nz:     taken = !z;
      cond_s:      taken = s;
      cond_ns:     taken = !s;
      cond_ugt:    taken = !c && !z;
      cond_ule:    taken = c || z;
      cond_uge:    taken = !c;
      cond_ult:    taken = c;
      cond_sgt:    taken = !lt && !z;
      cond_sle:    taken = lt || z;
      cond_sge:    taken = !lt;
      cond_slt:    taken = lt;
      cond_o:      taken = o;
      cond_no:     taken = !o;
      cond_p:      taken = p;
      default:     taken = 1'b1;  // cond_always
    endcase
  end

endmodule

`default_nettype wire

// File: design/add_sub_unit.sv
// add and sub unit
`timescale 1ns/1ps
`default_nettype none

module add_sub_unit (
  input  wire alu_ops_pkg::op_t     op,
  input  wire alu_ops_pkg::word_t   a,
  input  wire alu_ops_pkg::word_t   b,
  output logic                      hit,
  output alu_ops_pkg::word_t        sum,
  output alu_flags_pkg::flags_t     flags
);
  import alu_ops_pkg::*;
  import alu_flags_pkg::*;

  logic is_add, is_sub, is_half;
  word_t b_in;
  word_t raw;
  logic [4:0] lo_sum;               // bits 3..0
  logic [half_bits-4:0] mid_sum;    // bits 31..4
  logic [half_bits:0] hi_sum;       // bits 63..32
  logic c4, c32, c64;
  logic top_a, top_b, top_r, carry_top;

  assign is_add = (op == op_add64) || (op == op_add32);
  assign is_sub = (op == op_sub64) || (op == op_sub32);
  assign is_half = (op == op_add32) || (op == op_sub32);
  assign hit = is_add || is_sub;

  // a + ~b + 1 for sub
  assign b_in = is_sub ? ~b : b;

  // split adder so the carries out of bits 3, 31 and 63 are visible
  assign lo_sum = {1'b0, a[3:0]} + {1'b0, b_in[3:0]} + {4'b0, is_sub};
  assign c4 = lo_sum[4];
  assign mid_sum = {1'b0, a[half_bits-1:4]} + {1'b0, b_in[half_bits-1:4]}
                   + {{(half_bits-4){1'b0}}, c4};
  assign c32 = mid_sum[half_bits-4];
  assign hi_sum = {1'b0, a[word_bits-1:half_bits]} + {1'b0, b_in[word_bits-1:half_bits]}
                  + {{half_bits{1'b0}}, c32};
  assign c64 = hi_sum[half_bits];
  assign raw = {hi_sum[half_bits-1:0], mid_sum[half_bits-5:0], lo_sum[3:0]};

  assign sum = is_half ? {{half_bits{1'b0}}, raw[half_bits-1:0]} : raw;

  assign top_a = is_half ? a[half_bits-1] : a[word_bits-1];
  assign top_b = is_half ? b_in[half_bits-1] : b_in[word_bits-1];
  assign top_r = is_half ? raw[half_bits-1] : raw[word_bits-1];
  assign carry_top = is_half ? c32 : c64;

  always_comb begin
    flags = '0;
    flags[flag_c] = carry_top ^ is_sub;  // borrow on sub
    flags[flag_o] = (top_a == top_b) && (top_r != top_a);
    flags[flag_a] = c4 ^ is_sub;
    flags[flag_s] = top_r;
    flags[flag_z] = (sum == '0);
    flags[flag_p] = ~^raw[7:0];
  end

endmodule

`default_nettype wire

// File: design/logic_move_unit.sv
// bitwise, move and conditional unit
`timescale 1ns/1ps
`default_nettype none

module logic_move_unit (
  input  wire alu_ops_pkg::op_t       op,
  input  wire alu_flags_pkg::cond_t   cond,
  input  wire alu_flags_pkg::flags_t  flags_in,
  input  wire alu_ops_pkg::word_t     a,
  input  wire alu_ops_pkg::word_t     b,
  output logic                        hit,
  output logic                        sets_flags,
  output alu_ops_pkg::word_t          value,
  output alu_flags_pkg::flags_t       flags
);
  import alu_ops_pkg::*;
  import alu_flags_pkg::*;

  logic taken;
  logic is_bitwise;
  logic is_half;

  function automatic word_t lo_half(input word_t w);
    lo_half = {{half_bits{1'b0}}, w[half_bits-1:0]};
  endfunction

  cond_eval cond0 (
    .flags (flags_in),
    .cond  (cond),
    .taken (taken)
  );

  assign is_bitwise = (op >= op_and64) && (op <= op_xnor32);
  assign is_half = (op == op_and32) || (op == op_or32) || (op == op_xor32)
                   || (op == op_xnor32);

  always_comb begin
    hit = 1'b1;
    case (op)
      op_and64:  value = a & b;
      op_and32:  value = lo_half(a & b);
      op_or64:   value = a | b;
      op_or32:   value = lo_half(a | b);
      op_xor64:  value = a ^ b;
      op_xor32:  value = lo_half(a ^ b);
      op_xnor64: value = ~(a ^ b);
      op_xnor32: value = lo_half(~(a ^ b));
      op_mov64:  value = b;
      op_mov32:  value = lo_half(b);
      op_zxt8:   value = word_t'(b[7:0]);
      op_zxt16:  value = word_t'(b[15:0]);
      op_sxt8:   value = {{(word_bits-8){b[7]}}, b[7:0]};
      op_sxt16:  value = {{(word_bits-16){b[15]}}, b[15:0]};
      op_sxt32:  value = {{half_bits{b[half_bits-1]}}, b[half_bits-1:0]};
      op_cmov:   value = taken ? b : a;
      op_cset:   value = word_t'(taken);
      default: begin
        value = '0;  // arithmetic or unused code
        hit = 1'b0;
      end
    endcase
  end

  assign sets_flags = is_bitwise;

  always_comb begin
    flags = flags_in;  // moves leave the flags alone
    if (is_bitwise) begin
      flags = '0;
      flags[flag_s] = is_half ? value[half_bits-1] : value[word_bits-1];
      flags[flag_z] = (value == '0);
      flags[flag_p] = ~^value[7:0];
    end
  end

endmodule

`default_nettype wire

// File: design/result_stage.sv
// result select and output register
`timescale 1ns/1ps
`default_nettype none

module result_stage (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         in_valid,
  input  wire                         arith_hit,
  input  wire alu_ops_pkg::word_t     arith_value,
  input  wire alu_flags_pkg::flags_t  arith_flags,
  input  wire                         lm_hit,
  input  wire                         lm_sets_flags,
  input  wire alu_ops_pkg::word_t     lm_value,
  input  wire alu_flags_pkg::flags_t  lm_flags,
  input  wire alu_flags_pkg::flags_t  flags_in,
  output logic                        out_valid,
  output alu_ops_pkg::word_t          result,
  output alu_flags_pkg::flags_t       flags_out,
  output logic                        flags_wr
);
  import alu_ops_pkg::*;
  import alu_flags_pkg::*;

  word_t sel_value;
  flags_t sel_flags;
  logic sel_wr;

  // units decode disjoint opcode sets
  always_comb begin
    if (arith_hit) begin
      sel_value = arith_value;
      sel_flags = arith_flags;
      sel_wr = 1'b1;  // arithmetic always writes flags
    end else if (lm_hit) begin
      sel_value = lm_value;
      sel_flags = lm_flags;
      sel_wr = lm_sets_flags;
    end else begin
      sel_value = '0;   // unused opcode
      sel_flags = flags_in;
      sel_wr = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      flags_wr <= 1'b0;
      result <= '0;
      flags_out <= '0;
    end else begin
      out_valid <= in_valid;
      flags_wr <= in_valid && sel_wr;
      if (in_valid) begin
        result <= sel_value;
        flags_out <= sel_flags;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/int_alu.sv
// integer alu top level
`timescale 1ns/1ps
`default_nettype none

module int_alu (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         in_valid,
  input  wire alu_ops_pkg::op_t       op,
  input  wire alu_flags_pkg::cond_t   cond,
  input  wire alu_ops_pkg::word_t     a,
  input  wire alu_ops_pkg::word_t     b,
  input  wire alu_flags_pkg::flags_t  flags_in,
  output logic                        out_valid,
  output alu_ops_pkg::word_t          result,
  output alu_flags_pkg::flags_t       flags_out,
  output logic                        flags_wr
);
  import alu_ops_pkg::*;
  import alu_flags_pkg::*;

  logic arith_hit;
  word_t arith_value;
  flags_t arith_flags;
  logic lm_hit;
  logic lm_sets_flags;
  word_t lm_value;
  flags_t lm_flags;

  add_sub_unit arith0 (
    .op    (op),
    .a     (a),
    .b     (b),
    .hit   (arith_hit),
    .sum   (arith_value),
    .flags (arith_flags)
  );

  logic_move_unit lm0 (
    .op         (op),
    .cond       (cond),
    .flags_in   (flags_in),
    .a          (a),
    .b          (b),
    .hit        (lm_hit),
    .sets_flags (lm_sets_flags),
    .value      (lm_value),
    .flags      (lm_flags)
  );

  result_stage rs0 (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .arith_hit     (arith_hit),
    .arith_value   (arith_value),
    .arith_flags   (arith_flags),
    .lm_hit        (lm_hit),
    .lm_sets_flags (lm_sets_flags),
    .lm_value      (lm_value),
    .lm_flags      (lm_flags),
    .flags_in      (flags_in),
    .out_valid     (out_valid),
    .result        (result),
    .flags_out     (flags_out),
    .flags_wr      (flags_wr)
  );

endmodule

`default_nettype wire

// File: dv/int_alu_tb.sv
// integer alu testbench
`timescale 1ns/1ps
`default_nettype none

module int_alu_tb;
  import alu_ops_pkg::*;
  import alu_flags_pkg::*;

  typedef struct packed {
    logic   wr;
    flags_t flags;
    word_t  value;
  } expect_t;

  // reset, corners, a==b, arith, bitwise, moves, conditions, unused, mixed, drain
  localparam int test_cycles = 5 + 1 + 100 + 16 + 40 + 80 + 56 + 128 + 4 + 400 + 10;

  logic clk = 1'b0;
  logic rst, in_valid, out_valid, flags_wr;
  op_t op;
  cond_t cond;
  word_t a, b, result;
  flags_t flags_in, flags_out;
  logic [31:0] lfsr_state;
  string test_name;
  expect_t exp_q[$];
  string name_q[$];
  int stamp_q[$];
  int cyc, low_cycles, issued, checked;
  int word_errs, flag_errs, bit_errs, proto_errs;

  int_alu dut0 (
    .clk(clk), .rst(rst), .in_valid(in_valid), .op(op), .cond(cond), .a(a), .b(b),
    .flags_in(flags_in), .out_valid(out_valid), .result(result), .flags_out(flags_out),
    .flags_wr(flags_wr)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  task automatic take_bits(input int n, output word_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  // pairs of conditions differ by the low bit, except p and always
  function automatic logic cond_holds(input flags_t f, input cond_t cc);
    logic lt, base;
    lt = f[flag_s] ^ f[flag_o];
    case (cc[3:1])
      3'd0: base = f[flag_z];
      3'd1: base = f[flag_s];
      3'd2: base = !f[flag_c] && !f[flag_z];
      3'd3: base = !f[flag_c];
      3'd4: base = !lt && !f[flag_z];
      3'd5: base = !lt;
      3'd6: base = f[flag_o];
      default: base = f[flag_p];
    endcase
    return (cc == cond_always) ? 1'b1 : base ^ cc[0];
  endfunction

  function automatic expect_t ref_alu(input op_t o, input cond_t cc, input word_t x,
                                      input word_t y, input flags_t fi);
    expect_t e;
    logic half;
    word_t mask, xm, ym, r;
    logic [64:0] wide;
    int top;
    half = (o <= op_xnor32) && o[0];  // odd codes below 12 are the 32-bit forms
    mask = half ? 64'h0000_0000_ffff_ffff : '1;
    top = half ? 31 : 63;
    xm = x & mask;
    ym = y & mask;
    e.wr = 1'b0;
    e.flags = fi;
    case (o)
      op_add64, op_add32: begin
        wide = {1'b0, xm} + {1'b0, ym};
        r = wide[63:0] & mask;
        e.flags = '0;
        e.flags[flag_c] = half ? wide[32] : wide[64];
        e.flags[flag_o] = (xm[top] == ym[top]) && (r[top] != xm[top]);
        e.flags[flag_a] = ({1'b0, x[3:0]} + {1'b0, y[3:0]}) > 5'd15;
        e.wr = 1'b1;
      end
      op_sub64, op_sub32: begin
        r = (xm - ym) & mask;
        e.flags = '0;
        e.flags[flag_c] = xm < ym;
        e.flags[flag_o] = (xm[top] != ym[top]) && (r[top] != xm[top]);
        e.flags[flag_a] = x[3:0] < y[3:0];
        e.wr = 1'b1;
      end
      op_and64, op_and32, op_or64, op_or32, op_xor64, op_xor32, op_xnor64, op_xnor32: begin
        if (o <= op_and32) r = xm & ym;
        else if (o <= op_or32) r = xm | ym;
        else if (o <= op_xor32) r = xm ^ ym;
        else r = ~(xm ^ ym) & mask;
        e.flags = '0;
        e.wr = 1'b1;
      end
      op_mov64: r = y;
      op_mov32: r = y & 64'h0000_0000_ffff_ffff;
      op_zxt8: r = {56'b0, y[7:0]};
      op_zxt16: r = {48'b0, y[15:0]};
      op_sxt8: r = {{56{y[7]}}, y[7:0]};
      op_sxt16: r = {{48{y[15]}}, y[15:0]};
      op_sxt32: r = {{32{y[31]}}, y[31:0]};
      op_cmov: r = cond_holds(fi, cc) ? y : x;
      op_cset: r = {63'b0, cond_holds(fi, cc)};
      default: r = '0;  // unused code
    endcase
    if (e.wr) begin
      e.flags[flag_s] = r[top];
      e.flags[flag_z] = (r == '0);
      e.flags[flag_p] = ~^r[7:0];
    end
    e.value = r;
    return e;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      word_errs++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flags(input string name, input flags_t exp, input flags_t act);
    if (exp !== act) begin
      flag_errs++;
      $display("Error %s flags: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      bit_errs++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic issue(input string name, input op_t o, input cond_t cc, input word_t x,
                       input word_t y, input flags_t f);
    @(posedge clk);
    test_name <= name;
    in_valid <= 1'b1;
    op <= o;
    cond <= cc;
    a <= x;
    b <= y;
    flags_in <= f;
  endtask

  task automatic idle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic issue_random(input string name, input op_t o);
    word_t x, y, t, u;
    take_bits(64, x);
    take_bits(64, y);
    take_bits(6, t);
    take_bits(4, u);
    issue(name, o, u[3:0], x, y, t[5:0]);
  endtask

  // outputs are read at the falling edge, one cycle after the issue was seen
  always @(negedge clk) begin
    expect_t e;
    string nm;
    int st;
    if (rst || low_cycles == 0) begin
      check_bit("reset out_valid", 1'b0, out_valid);
      check_bit("reset flags_wr", 1'b0, flags_wr);
      check_word("reset result", '0, result);
      check_flags("reset", '0, flags_out);
      if (!rst) low_cycles++;
    end else begin
      if (out_valid && exp_q.size() == 0) begin
        proto_errs++;
        $display("out_valid was high with no operation outstanding");
      end else if (out_valid) begin
        e = exp_q.pop_front();
        nm = name_q.pop_front();
        st = stamp_q.pop_front();
        if (cyc != st + 1) begin
          proto_errs++;
          $display("%s: result came %0d cycles after issue instead of one", nm, cyc - st);
        end
        check_word(nm, e.value, result);
        check_flags(nm, e.flags, flags_out);
        check_bit({nm, " flags_wr"}, e.wr, flags_wr);
        checked++;
      end else begin
        check_bit("idle flags_wr", 1'b0, flags_wr);
        if (stamp_q.size() != 0 && stamp_q[0] + 1 <= cyc) begin
          proto_errs++;
          $display("%s: no result one cycle after issue", name_q[0]);
          void'(exp_q.pop_front());
          void'(name_q.pop_front());
          void'(stamp_q.pop_front());
        end
      end
      if (in_valid) begin
        exp_q.push_back(ref_alu(op, cond, a, b, flags_in));
        name_q.push_back(test_name);
        stamp_q.push_back(cyc);
        issued++;
      end
    end
    cyc++;
  end

  initial begin
    #((test_cycles + 50) * 20);
    $display("watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    word_t corner[5];
    word_t x, y, t;
    rst = 1'b1;
    in_valid = 1'b0;
    op = '0;
    cond = '0;
    a = '0;
    b = '0;
    flags_in = '0;
    lfsr_state = 32'd12;
    test_name = "reset";
    corner[0] = '0;
    corner[1] = '1;
    corner[2] = 64'h8000_0000_0000_0000;
    corner[3] = 64'h0000_0000_8000_0000;  // signed min of the half width
    corner[4] = 64'd1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    idle();
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 5; j++) begin
        for (int k = 0; k < 5; k++) issue("arith corner", op_t'(i), cond_always, corner[j],
                                          corner[k], '0);
      end
      for (int n = 0; n < 4; n++) begin
        take_bits(64, x);
        take_bits(6, t);
        issue("arith a equal b", op_t'(i), cond_always, x, x, t[5:0]);
      end
      for (int n = 0; n < 10; n++) issue_random("arith random", op_t'(i));
    end
    for (int i = 4; i < 12; i++) begin
      for (int n = 0; n < 10; n++) issue_random("bitwise", op_t'(i));
    end
    idle();
    for (int i = 12; i < 19; i++) begin
      for (int n = 0; n < 8; n++) issue_random("move extend", op_t'(i));
    end
    for (int c = 0; c < 16; c++) begin
      for (int n = 0; n < 8; n++) begin
        take_bits(64, x);
        take_bits(64, y);
        take_bits(6, t);  // flags_in
        issue("cmov cset", (n < 4) ? op_cmov : op_cset, cond_t'(c), x, y, t[5:0]);
      end
    end
    issue_random("unused op", op_t'(21));
    issue_random("unused op", op_t'(25));
    issue_random("unused op", op_t'(28));
    issue_random("unused op", op_t'(31));
    for (int n = 0; n < 200; n++) begin
      take_bits(7, t);
      if (t[6:5] == 2'b00) idle();  // gap in the stream
      issue_random("mixed", (t[4:0] > 5'd20) ? t[4:0] - 5'd11 : t[4:0]);
    end
    idle();
    while (exp_q.size() != 0) @(posedge clk);
    @(posedge clk);
    if (issued != checked) begin
      proto_errs++;
      $display("issued %0d operations but checked %0d results", issued, checked);
    end
    $display("errors: result %0d, flags %0d, bits %0d, protocol %0d", word_errs, flag_errs,
             bit_errs, proto_errs);
    if (word_errs + flag_errs + bit_errs + proto_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
design/alu_ops_pkg.sv
design/alu_flags_pkg.sv
design/cond_eval.sv
design/add_sub_unit.sv
design/logic_move_unit.sv
design/result_stage.sv
design/int_alu.sv
dv/int_alu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the int_alu testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module int_alu_tb -f vlog.f -o int_alu_sim
./obj_dir/int_alu_sim | tee sim.log

if grep -qx "TB PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
